// ==== Makefile ====
TOP = fifo_shared_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "TEST PASSED" sim.log

obj_dir/V$(TOP): src.f src/*.sv testbench/*.sv include/*.svh
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module fifo_shared_top

clean:
	rm -rf obj_dir sim.log

// ==== include/fifo_shared_config.svh ====
// Shared FIFO configuration
`ifndef FIFO_SHARED_CONFIG_SVH
`define FIFO_SHARED_CONFIG_SVH

////////////////////////////////////////////////////////////
// Queue and pool sizing
////////////////////////////////////////////////////////////

// Number of queues sharing the pool.
`define FS_NUM_QUEUES 2

// Pool entries shared by all queues.
`define FS_DEPTH 8

// Width of one stored item.
`define FS_WIDTH 8

// Most pop credits one queue can hold.
`define FS_POP_MAX_CREDITS 2

////////////////////////////////////////////////////////////
// Configuration port
////////////////////////////////////////////////////////////

`define FS_CFG_ADDR_WIDTH 4
`define FS_CFG_WORD_WIDTH 16

`endif

// ==== src.f ====
+incdir+include
src/fifo_shared_pkg.sv
src/fifo_shared_push_credit.sv
src/fifo_shared_linked_store.sv
src/fifo_shared_pop_sched.sv
src/fifo_shared_cfg.sv
src/fifo_shared_top.sv
testbench/fifo_shared_tb.sv

// ==== src/fifo_shared_cfg.sv ====
// Configuration register block
`timescale 1ns/1ps
`default_nettype none

`include "fifo_shared_config.svh"

module fifo_shared_cfg (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         cfg_req,
  input  logic                                         cfg_write,
  input  fifo_shared_pkg::cfg_addr_t                   cfg_addr,
  input  fifo_shared_pkg::cfg_word_t                   cfg_wdata,
  output logic                                         cfg_ack,
  output fifo_shared_pkg::cfg_word_t                   cfg_rdata,
  input  fifo_shared_pkg::count_t [`FS_NUM_QUEUES-1:0] counts,
  input  logic                                         overflow,
  output logic [`FS_NUM_QUEUES-1:0]                    pause_mask,
  output logic                                         clear_overflow
);
  import fifo_shared_pkg::*;

  logic      op_start;
  cfg_word_t read_word;

  // Request seen high while ack is still low.
  assign op_start = cfg_req && !cfg_ack;
  assign clear_overflow = op_start && cfg_write && (cfg_addr == cfg_addr_overflow);

  always_comb begin
    read_word = '0;
    if (cfg_addr == cfg_addr_pause) begin
      read_word = cfg_word_t'(pause_mask);
    end else if (cfg_addr == cfg_addr_overflow) begin
      read_word = cfg_word_t'(overflow);
    end
    for (int q = 0; q < `FS_NUM_QUEUES; q++) begin
      if (cfg_addr == cfg_addr_t'(cfg_addr_count + q)) begin
        read_word = cfg_word_t'(counts[q]);
      end
    end
  end

  // Ack follows req by one cycle in both directions.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_ack <= 1'b0;
      pause_mask <= '0;
    end else begin
      cfg_ack <= cfg_req;
      if (op_start && cfg_write && (cfg_addr == cfg_addr_pause)) begin
        pause_mask <= cfg_wdata[`FS_NUM_QUEUES-1:0];
      end
    end
  end

  // Read data holds from ack rise until the next request.
  always_ff @(posedge clk) begin
    if (op_start) begin
      cfg_rdata <= read_word;
    end
  end

endmodule

`default_nettype wire

// ==== src/fifo_shared_linked_store.sv ====
// Shared pool with per-queue linked lists
`timescale 1ns/1ps
`default_nettype none

`include "fifo_shared_config.svh"

module fifo_shared_linked_store (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           accept_valid,
  input  fifo_shared_pkg::data_t                         accept_data,
  input  fifo_shared_pkg::qid_t                          accept_qid,
  input  logic                                           pop_req,
  input  fifo_shared_pkg::qid_t                          pop_req_qid,
  output fifo_shared_pkg::data_t                         head_data,
  output logic                                           free_pulse,
  output fifo_shared_pkg::count_t [`FS_NUM_QUEUES-1:0]   counts
);
  import fifo_shared_pkg::*;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  data_t  data_mem   [`FS_DEPTH];
  ptr_t   next_ptr   [`FS_DEPTH];
  ptr_t   free_stack [`FS_DEPTH];
  count_t free_count;

  ptr_t   head_ptr   [`FS_NUM_QUEUES];
  ptr_t   tail_ptr   [`FS_NUM_QUEUES];
  count_t [`FS_NUM_QUEUES-1:0] item_count;

  logic [`FS_NUM_QUEUES-1:0] push_hit;
  logic [`FS_NUM_QUEUES-1:0] pop_hit;
  logic [`FS_NUM_QUEUES-1:0] push_to_empty;

  ptr_t alloc_ptr;
  ptr_t pop_ptr;

  // Top of the free stack is the next entry handed out.
  assign alloc_ptr = free_stack[ptr_t'(free_count - 1'b1)];
  assign pop_ptr = head_ptr[pop_req_qid];

  assign head_data = data_mem[pop_ptr];
  assign free_pulse = pop_req;
  assign counts = item_count;

  always_comb begin
    for (int q = 0; q < `FS_NUM_QUEUES; q++) begin
      push_hit[q] = accept_valid && (accept_qid == qid_t'(q));
      pop_hit[q] = pop_req && (pop_req_qid == qid_t'(q));
      // Popping the last item while pushing also makes the new entry the head.
      push_to_empty[q] = push_hit[q] &&
                         ((item_count[q] == '0) ||
                          (pop_hit[q] && (item_count[q] == count_t'(1))));
    end
  end

  ////////////////////////////////////////////////////////////
  // Free list
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      free_count <= count_t'(`FS_DEPTH);
      for (int i = 0; i < `FS_DEPTH; i++) begin
        free_stack[i] <= ptr_t'(i);
      end
    end else begin
      if (accept_valid && pop_req) begin
        // Freed entry takes the slot of the one just allocated.
        free_stack[ptr_t'(free_count - 1'b1)] <= pop_ptr;
      end else if (accept_valid) begin
        free_count <= free_count - 1'b1;
      end else if (pop_req) begin
        free_stack[ptr_t'(free_count)] <= pop_ptr;
        free_count <= free_count + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Entry payload and links
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept_valid) begin
      data_mem[alloc_ptr] <= accept_data;
      if (!push_to_empty[accept_qid]) begin
        next_ptr[tail_ptr[accept_qid]] <= alloc_ptr;
      end
    end
  end

  // Per-queue head, tail and count.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int q = 0; q < `FS_NUM_QUEUES; q++) begin
        head_ptr[q] <= '0;
        tail_ptr[q] <= '0;
        item_count[q] <= '0;
      end
    end else begin
      for (int q = 0; q < `FS_NUM_QUEUES; q++) begin
        if (push_to_empty[q]) begin
          head_ptr[q] <= alloc_ptr;
        end else if (pop_hit[q]) begin
          head_ptr[q] <= next_ptr[head_ptr[q]];
        end
        if (push_hit[q]) begin
          tail_ptr[q] <= alloc_ptr;
        end
        item_count[q] <= item_count[q] + count_t'(push_hit[q]) - count_t'(pop_hit[q]);
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/fifo_shared_pkg.sv ====
// Shared FIFO types
`default_nettype none

`include "fifo_shared_config.svh"

package fifo_shared_pkg;

  // Queue id is at least one bit wide.
  localparam int qid_width = (`FS_NUM_QUEUES > 1) ? $clog2(`FS_NUM_QUEUES) : 1;
  localparam int ptr_width = $clog2(`FS_DEPTH);
  localparam int count_width = $clog2(`FS_DEPTH + 1);

  typedef logic [`FS_WIDTH-1:0] data_t;
  typedef logic [qid_width-1:0] qid_t;
  typedef logic [ptr_width-1:0] ptr_t;
  typedef logic [count_width-1:0] count_t;

  typedef logic [`FS_CFG_ADDR_WIDTH-1:0] cfg_addr_t;
  typedef logic [`FS_CFG_WORD_WIDTH-1:0] cfg_word_t;

  // Register map.
  localparam cfg_addr_t cfg_addr_pause = cfg_addr_t'(0);
  localparam cfg_addr_t cfg_addr_overflow = cfg_addr_t'(1);
  // Item counts start at this address with one word per queue
  localparam cfg_addr_t cfg_addr_count = cfg_addr_t'(2);

endpackage

`default_nettype wire

// ==== src/fifo_shared_pop_sched.sv ====
// Pop credit scheduler
`timescale 1ns/1ps
`default_nettype none

`include "fifo_shared_config.svh"

module fifo_shared_pop_sched (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  fifo_shared_pkg::count_t [`FS_NUM_QUEUES-1:0] counts,
  input  logic [`FS_NUM_QUEUES-1:0]                    pause_mask,
  input  logic [`FS_NUM_QUEUES-1:0]                    pop_credit,
  output logic                                         pop_req,
  output fifo_shared_pkg::qid_t                        pop_req_qid,
  input  fifo_shared_pkg::data_t                       head_data,
  output logic                                         pop_valid,
  output fifo_shared_pkg::data_t                       pop_data,
  output fifo_shared_pkg::qid_t                        pop_qid
);
  import fifo_shared_pkg::*;

  localparam int credit_width = $clog2(`FS_POP_MAX_CREDITS + 1);

  logic [credit_width-1:0] credit_q [`FS_NUM_QUEUES];

  logic [`FS_NUM_QUEUES-1:0] in_flight;
  logic [`FS_NUM_QUEUES-1:0] eligible;
  logic [`FS_NUM_QUEUES-1:0] spend;
  logic                      pick_valid;
  qid_t                      pick_qid;

  ////////////////////////////////////////////////////////////
  // Eligibility and round-robin pick
  ////////////////////////////////////////////////////////////

  // The pending pop has not left the store count yet.
  always_comb begin
    for (int q = 0; q < `FS_NUM_QUEUES; q++) begin
      in_flight[q] = pop_req && (pop_req_qid == qid_t'(q));
      eligible[q] = !pause_mask[q] && (credit_q[q] != '0) &&
                    (counts[q] > count_t'(in_flight[q]));
    end
  end

  // Search starts after the last queue picked.
  always_comb begin
    pick_valid = 1'b0;
    pick_qid = '0;
    for (int i = 1; i <= `FS_NUM_QUEUES; i++) begin
      if (!pick_valid && eligible[(int'(pop_req_qid) + i) % `FS_NUM_QUEUES]) begin
        pick_valid = 1'b1;
        pick_qid = qid_t'((int'(pop_req_qid) + i) % `FS_NUM_QUEUES);
      end
    end
  end

  always_comb begin
    for (int q = 0; q < `FS_NUM_QUEUES; q++) begin
      spend[q] = pick_valid && (pick_qid == qid_t'(q));
    end
  end

  ////////////////////////////////////////////////////////////
  // Credits, decision and output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pop_req <= 1'b0;
      pop_req_qid <= '0;
      pop_valid <= 1'b0;
      for (int q = 0; q < `FS_NUM_QUEUES; q++) begin
        credit_q[q] <= '0;
      end
    end else begin
      pop_req <= pick_valid;
      if (pick_valid) begin
        pop_req_qid <= pick_qid;
      end
      pop_valid <= pop_req;
      for (int q = 0; q < `FS_NUM_QUEUES; q++) begin
        if (pop_credit[q] && !spend[q] &&
            (credit_q[q] != credit_width'(`FS_POP_MAX_CREDITS))) begin
          credit_q[q] <= credit_q[q] + 1'b1;
        end else if (spend[q] && !pop_credit[q]) begin
          credit_q[q] <= credit_q[q] - 1'b1;
        end
      end
    end
  end

  // Head data is read on the same edge the store deallocates.
  always_ff @(posedge clk) begin
    if (pop_req) begin
      pop_data <= head_data;
      pop_qid <= pop_req_qid;
    end
  end

endmodule

`default_nettype wire

// ==== src/fifo_shared_push_credit.sv ====
// Push side credit receiver
`timescale 1ns/1ps
`default_nettype none

`include "fifo_shared_config.svh"

module fifo_shared_push_credit (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_valid,
  input  fifo_shared_pkg::data_t push_data,
  input  fifo_shared_pkg::qid_t  push_qid,
  input  logic                   free_pulse,
  input  logic                   clear_overflow,
  output logic                   push_credit,
  output logic                   accept_valid,
  output fifo_shared_pkg::data_t accept_data,
  output fifo_shared_pkg::qid_t  accept_qid,
  output logic                   overflow
);
  import fifo_shared_pkg::*;

  // Credits still owed to the sender, and credits granted but unused.
  count_t return_count;
  count_t granted_count;
  logic   credit_out;
  logic   have_credit;
  logic   drop;

  // One credit leaves per cycle and freed entries queue behind the initial ones.
  assign credit_out = (return_count != '0) || free_pulse;

  // A credit pulse in the same cycle already counts as held.
  assign have_credit = (granted_count != '0) || push_credit;
  assign drop = push_valid && !have_credit;

  assign accept_valid = push_valid && have_credit;
  assign accept_data = push_data;
  assign accept_qid = push_qid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      return_count <= count_t'(`FS_DEPTH);
      granted_count <= '0;
      push_credit <= 1'b0;
      overflow <= 1'b0;
    end else begin
      return_count <= return_count + count_t'(free_pulse) - count_t'(credit_out);
      granted_count <= granted_count + count_t'(push_credit) - count_t'(accept_valid);
      push_credit <= credit_out;
      // Sticky until cleared. A new drop wins over the clear.
      overflow <= (overflow && !clear_overflow) || drop;
    end
  end

endmodule

`default_nettype wire

// ==== src/fifo_shared_top.sv ====
// Shared multi-queue FIFO top
`timescale 1ns/1ps
`default_nettype none

`include "fifo_shared_config.svh"

module fifo_shared_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             push_valid,
  input  fifo_shared_pkg::data_t           push_data,
  input  fifo_shared_pkg::qid_t            push_qid,
  output logic                             push_credit,
  output logic                             pop_valid,
  output fifo_shared_pkg::data_t           pop_data,
  output fifo_shared_pkg::qid_t            pop_qid,
  input  logic [`FS_NUM_QUEUES-1:0]        pop_credit,
  input  logic                             cfg_req,
  input  logic                             cfg_write,
  input  fifo_shared_pkg::cfg_addr_t       cfg_addr,
  input  fifo_shared_pkg::cfg_word_t       cfg_wdata,
  output logic                             cfg_ack,
  output fifo_shared_pkg::cfg_word_t       cfg_rdata
);
  import fifo_shared_pkg::*;

  logic                       accept_valid;
  data_t                      accept_data;
  qid_t                       accept_qid;
  logic                       free_pulse;
  logic                       overflow;
  logic                       clear_overflow;
  logic                       pop_req;
  qid_t                       pop_req_qid;
  data_t                      head_data;
  logic [`FS_NUM_QUEUES-1:0]  pause_mask;
  count_t [`FS_NUM_QUEUES-1:0] counts;

  fifo_shared_push_credit u_push_credit (
    .clk            (clk),
    .rst_n          (rst_n),
    .push_valid     (push_valid),
    .push_data      (push_data),
    .push_qid       (push_qid),
    .free_pulse     (free_pulse),
    .clear_overflow (clear_overflow),
    .push_credit    (push_credit),
    .accept_valid   (accept_valid),
    .accept_data    (accept_data),
    .accept_qid     (accept_qid),
    .overflow       (overflow)
  );

  fifo_shared_linked_store u_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .accept_valid (accept_valid),
    .accept_data  (accept_data),
    .accept_qid   (accept_qid),
    .pop_req      (pop_req),
    .pop_req_qid  (pop_req_qid),
    .head_data    (head_data),
    .free_pulse   (free_pulse),
    .counts       (counts)
  );

  fifo_shared_pop_sched u_pop_sched (
    .clk         (clk),
    .rst_n       (rst_n),
    .counts      (counts),
    .pause_mask  (pause_mask),
    .pop_credit  (pop_credit),
    .pop_req     (pop_req),
    .pop_req_qid (pop_req_qid),
    .head_data   (head_data),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .pop_qid     (pop_qid)
  );

  fifo_shared_cfg u_cfg (
    .clk            (clk),
    .rst_n          (rst_n),
    .cfg_req        (cfg_req),
    .cfg_write      (cfg_write),
    .cfg_addr       (cfg_addr),
    .cfg_wdata      (cfg_wdata),
    .cfg_ack        (cfg_ack),
    .cfg_rdata      (cfg_rdata),
    .counts         (counts),
    .overflow       (overflow),
    .pause_mask     (pause_mask),
    .clear_overflow (clear_overflow)
  );

endmodule

`default_nettype wire

// ==== include/fifo_shared_tb_tests.svh ====
// Shared FIFO directed tests
`ifndef FIFO_SHARED_TB_TESTS_SVH
`define FIFO_SHARED_TB_TESTS_SVH

////////////////////////////////////////////////////////////
// Push and config port drivers
////////////////////////////////////////////////////////////

task automatic push_item(input qid_t q, input data_t d);
  while (credits_held == 0) begin
    wait_cycles(1);
  end
  credits_held--;
  sb[q].push_back(d);
  push_valid = 1'b1;
  push_data = d;
  push_qid = q;
  wait_cycles(1);
  push_valid = 1'b0;
endtask

task automatic push_random(input qid_t q);
  rand_state = xorshift32(rand_state);
  push_item(q, data_t'(rand_state[7:0]));
endtask

// No credit held, so the item must never show up.
task automatic push_without_credit(input qid_t q, input data_t d);
  push_valid = 1'b1;
  push_data = d;
  push_qid = q;
  wait_cycles(1);
  push_valid = 1'b0;
endtask

task automatic cfg_access(input logic write, input cfg_addr_t addr, input cfg_word_t wdata,
                          output cfg_word_t rdata);
  cfg_req = 1'b1;
  cfg_write = write;
  cfg_addr = addr;
  cfg_wdata = wdata;
  wait_cycles(1);
  while (!cfg_ack) begin
    wait_cycles(1);
  end
  rdata = cfg_rdata;
  cfg_req = 1'b0;
  wait_cycles(1);
  while (cfg_ack) begin
    wait_cycles(1);
  end
endtask

task automatic write_reg(input cfg_addr_t addr, input cfg_word_t wdata);
  cfg_word_t unused_word;
  cfg_access(1'b1, addr, wdata, unused_word);
endtask

task automatic expect_reg(input string name, input cfg_addr_t addr, input cfg_word_t exp);
  cfg_word_t got;
  cfg_access(1'b0, addr, '0, got);
  check_word(name, got, exp);
endtask

function automatic int pending_items();
  int total;
  total = 0;
  for (int q = 0; q < `FS_NUM_QUEUES; q++) begin
    total += sb[q].size();
  end
  return total;
endfunction

task automatic wait_drained();
  while (pending_items() != 0) begin
    wait_cycles(1);
  end
  wait_cycles(8);
endtask

////////////////////////////////////////////////////////////
// Tests
////////////////////////////////////////////////////////////

task automatic run_initial_credits();
  $display("Initial push credits");
  while (credit_pulses < `FS_DEPTH) begin
    wait_cycles(1);
  end
  wait_cycles(10);
  check_count("push_credit pulses", credit_pulses, `FS_DEPTH);
  expect_reg("overflow", 4'd1, '0);
  expect_reg("count q0", 4'd2, '0);
endtask

task automatic run_queue_order();
  logic [31:0] r;
  $display("Per-queue order");
  for (int i = 0; i < 12; i++) begin
    rand_state = xorshift32(rand_state);
    r = rand_state;
    push_item(qid_t'(r[20:16] % `FS_NUM_QUEUES), data_t'(r[15:8]));
  end
  wait_drained();
endtask

task automatic run_gating_and_pause();
  int base;
  $display("Pop credit gating and pause");
  // Queue 1 keeps its two credits but gets none back.
  ret_enable[1] = 1'b0;
  base = pops_seen;
  push_random(1);
  push_random(1);
  push_random(1);
  push_random(0);
  while (pops_seen < base + 3) begin
    wait_cycles(1);
  end
  wait_cycles(20);
  if (sb[1].size() != 1) begin
    other_errors++;
    $display("Queue 1 sent an item without pop credit");
  end
  expect_reg("count q1", 4'd3, cfg_word_t'(sb[1].size()));
  ret_enable[1] = 1'b1;
  wait_drained();

  write_reg(4'd0, 16'h0001);
  base = pops_seen;
  push_random(0);
  push_random(0);
  push_random(1);
  while (pops_seen == base) begin
    wait_cycles(1);
  end
  // Only the queue 1 item may pass while queue 0 is paused.
  check_qid("pop_qid", last_pop_qid, 1);
  wait_cycles(20);
  if (sb[0].size() != 2) begin
    other_errors++;
    $display("Queue 0 sent an item while paused");
  end
  expect_reg("count q0", 4'd2, cfg_word_t'(sb[0].size()));
  expect_reg("pause mask", 4'd0, 16'h0001);
  write_reg(4'd0, 16'h0000);
  wait_drained();
  expect_reg("count q0", 4'd2, '0);
  expect_reg("count q1", 4'd3, '0);
endtask

task automatic run_shared_pool();
  int base;
  $display("Shared pool fill and drain");
  check_count("credits held", credits_held, `FS_DEPTH);
  base = credit_pulses;
  write_reg(4'd0, 16'h0001);
  for (int i = 0; i < `FS_DEPTH; i++) begin
    push_random(0);
  end
  wait_cycles(10);
  check_count("push_credit pulses", credit_pulses - base, 0);
  expect_reg("count q0", 4'd2, cfg_word_t'(`FS_DEPTH));
  write_reg(4'd0, 16'h0000);
  wait_drained();
  while (credit_pulses - base < `FS_DEPTH) begin
    wait_cycles(1);
  end
  wait_cycles(10);
  check_count("push_credit pulses", credit_pulses - base, `FS_DEPTH);
endtask

task automatic run_overflow();
  $display("Push overflow");
  write_reg(4'd0, 16'h0001);
  for (int i = 0; i < `FS_DEPTH; i++) begin
    push_random(0);
  end
  wait_cycles(4);
  if (credits_held != 0) begin
    other_errors++;
    $display("Push credits arrived with the pool full");
  end
  rand_state = xorshift32(rand_state);
  push_without_credit(0, data_t'(rand_state[7:0]));
  expect_reg("overflow", 4'd1, 16'h0001);
  expect_reg("count q0", 4'd2, cfg_word_t'(sb[0].size()));
  write_reg(4'd1, 16'h0001);
  expect_reg("overflow", 4'd1, '0);
  write_reg(4'd0, 16'h0000);
  wait_drained();
  while (credits_held < `FS_DEPTH) begin
    wait_cycles(1);
  end
  wait_cycles(10);
  check_count("credits held", credits_held, `FS_DEPTH);
endtask

`endif

// ==== testbench/fifo_shared_tb.sv ====
// Shared FIFO testbench
`timescale 1ns/1ps
`default_nettype none

`include "fifo_shared_config.svh"

module fifo_shared_tb;
  import fifo_shared_pkg::*;

  // Rough cycle lengths of the tests.
  localparam int init_cycles = 40;
  localparam int order_cycles = 200;
  localparam int gate_cycles = 200;
  localparam int pool_cycles = 120;
  localparam int overflow_cycles = 120;
  localparam int timeout_cycles =
    4 * (init_cycles + order_cycles + gate_cycles + pool_cycles + overflow_cycles);

  logic                      clk;
  logic                      rst_n;
  logic                      push_valid;
  data_t                     push_data;
  qid_t                      push_qid;
  logic                      push_credit;
  logic                      pop_valid;
  data_t                     pop_data;
  qid_t                      pop_qid;
  logic [`FS_NUM_QUEUES-1:0] pop_credit;
  logic                      cfg_req;
  logic                      cfg_write;
  cfg_addr_t                 cfg_addr;
  cfg_word_t                 cfg_wdata;
  logic                      cfg_ack;
  cfg_word_t                 cfg_rdata;

  // Expected items per queue, oldest first.
  data_t sb [`FS_NUM_QUEUES][$];

  int                        credits_held;
  int                        credit_pulses;
  int                        pops_seen;
  qid_t                      last_pop_qid;
  int                        owed [`FS_NUM_QUEUES];
  logic [`FS_NUM_QUEUES-1:0] ret_enable;
  logic                      out_of_reset;
  logic [31:0]               rand_state;
  int                        cycle_count;
  int                        checks;
  int                        value_errors;
  int                        other_errors;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  fifo_shared_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .push_qid    (push_qid),
    .push_credit (push_credit),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .pop_qid     (pop_qid),
    .pop_credit  (pop_credit),
    .cfg_req     (cfg_req),
    .cfg_write   (cfg_write),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_ack     (cfg_ack),
    .cfg_rdata   (cfg_rdata)
  );

  ////////////////////////////////////////////////////////////
  // Helpers and compare tasks
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_qid(input string name, input qid_t got, input qid_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input cfg_word_t got, input cfg_word_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // Tallies kept by the testbench itself.
  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      other_errors++;
      $display("Counted %0d %s where %0d were expected", got, what, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor, pop credit receiver and watchdog
  ////////////////////////////////////////////////////////////

  // Outputs are registered, so the falling edge sees them settled.
  always @(negedge clk) begin
    if (rst_n) begin
      if (push_credit) begin
        credits_held++;
        credit_pulses++;
      end
      if (pop_valid) begin
        pops_seen++;
        last_pop_qid = pop_qid;
        owed[pop_qid]++;
        if (sb[pop_qid].size() == 0) begin
          other_errors++;
          $display("Unexpected item 0x%h on queue %0d", pop_data, pop_qid);
        end else begin
          check_data("pop_data", pop_data, sb[pop_qid].pop_front());
        end
      end
    end
  end

  // Receiver with room for FS_POP_MAX_CREDITS items per queue.
  // Every consumed item hands its credit back.
  initial begin
    pop_credit = '0;
    forever begin
      @(posedge clk);
      out_of_reset = rst_n;
      #1;
      for (int q = 0; q < `FS_NUM_QUEUES; q++) begin
        if (out_of_reset && ret_enable[q] && (owed[q] > 0)) begin
          pop_credit[q] = 1'b1;
          owed[q]--;
        end else begin
          pop_credit[q] = 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Run stopped after %0d cycles without finishing", timeout_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  `include "fifo_shared_tb_tests.svh"

  initial begin
    rst_n = 1'b0;
    push_valid = 1'b0;
    push_data = '0;
    push_qid = '0;
    cfg_req = 1'b0;
    cfg_write = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    credits_held = 0;
    credit_pulses = 0;
    pops_seen = 0;
    last_pop_qid = '0;
    ret_enable = '1;
    for (int q = 0; q < `FS_NUM_QUEUES; q++) begin
      owed[q] = `FS_POP_MAX_CREDITS;
    end
    rand_state = 32'hd6250dbe;
    cycle_count = 0;
    checks = 0;
    value_errors = 0;
    other_errors = 0;

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    run_initial_credits();
    run_queue_order();
    run_gating_and_pause();
    run_shared_pool();
    run_overflow();

    $display("Summary: %0d checks, %0d value errors, %0d other errors",
             checks, value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
